// ==== Bender.yml ====
package:
  name: mac_rx_gmii

sources:
  # design, packages first
  - files:
      - source/eth_frame_pkg.sv
      - source/mac_rx_pkg.sv
      - source/gmii_rx_framer.sv
      - source/frame_ram.sv
      - source/crc32_8023.sv
      - source/frame_unloader.sv
      - source/mac_rx_gmii.sv

  # testbench and bound assertions
  - target: test
    files:
      - tests/mac_rx_gmii_properties.sv
      - tests/mac_rx_gmii_tb.sv

// ==== mac_rx_gmii.f ====
source/eth_frame_pkg.sv
source/mac_rx_pkg.sv
source/gmii_rx_framer.sv
source/frame_ram.sv
source/crc32_8023.sv
source/frame_unloader.sv
source/mac_rx_gmii.sv
tests/mac_rx_gmii_properties.sv
tests/mac_rx_gmii_tb.sv

// ==== source/crc32_8023.sv ====
`timescale 1ns/1ns

module crc32_8023 (
  input  logic              rx_clk,
  input  logic              rstn_mac,
  input  logic              init,
  input  logic              calc,
  input  mac_rx_pkg::byte_t data,
  output mac_rx_pkg::crc_t  crc
);
  import mac_rx_pkg::*;

  localparam crc_t POLY = 32'h04C1_1DB7;

  crc_t crc_q;

  // one byte through the 802.3 shift register, lsb of the byte first
  function automatic crc_t crc_step(crc_t cur, byte_t d);
    crc_t nxt;
    logic fb;
    nxt = cur;
    for (int i = 0; i < $bits(byte_t); i++) begin
      fb  = nxt[$bits(crc_t)-1] ^ d[i];
      nxt = {nxt[$bits(crc_t)-2:0], 1'b0};
      if (fb) begin
        nxt = nxt ^ POLY;
      end
    end
    return nxt;
  endfunction

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      crc_q <= '1;
    end else if (init) begin
      crc_q <= '1;  // preset for a new frame
    end else if (calc) begin
      crc_q <= crc_step(crc_q, data);
    end
  end

  assign crc = crc_q;

endmodule

// ==== source/eth_frame_pkg.sv ====
package eth_frame_pkg;

  // ====================
  // delimiters
  // ====================
  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0] SFD_BYTE      = 8'hD5;

  // ====================
  // frame classification
  // ====================

  // first ethertype byte of a time-triggered frame
  localparam logic [7:0] TTE_TYPE_BYTE   = 8'h92;
  localparam int         TYPE_BYTE_INDEX = 12;  // byte index after the sfd

  // ====================
  // frame checks
  // ====================

  // left behind in the crc register by a frame with a good fcs
  localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

  localparam int MIN_FRAME_LEN = 64;    // shorter is a runt
  localparam int MAX_LEGAL_LEN = 1518;  // longer is a giant

endpackage

// ==== source/frame_ram.sv ====
`timescale 1ns/1ns

module frame_ram (
  input  logic                  rx_clk,
  input  logic                  wr_en,
  input  mac_rx_pkg::ram_addr_t wr_addr,
  input  mac_rx_pkg::byte_t     wr_data,
  input  mac_rx_pkg::ram_addr_t rd_addr,
  output mac_rx_pkg::byte_t     rd_data
);
  import mac_rx_pkg::*;

  // two slots of 2048 bytes, slot picked by the top address bit
  localparam int DEPTH = 2 ** RAM_ADDR_W;

  byte_t mem [DEPTH];

  // ====================
  // write port
  // ====================
  always_ff @(posedge rx_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ====================
  // read port
  // ====================
  always_ff @(posedge rx_clk) begin
    rd_data <= mem[rd_addr];  // one cycle after rd_addr
  end

endmodule

// ==== source/frame_unloader.sv ====
`timescale 1ns/1ns

module frame_unloader (
  input  logic                    rx_clk,
  input  logic                    rstn_mac,
  input  mac_rx_pkg::frame_load_t load,
  output mac_rx_pkg::ram_addr_t   rd_addr,
  input  mac_rx_pkg::byte_t       rd_data,
  output mac_rx_pkg::rx_byte_t    rx_byte,
  output mac_rx_pkg::rx_desc_t    rx_desc
);
  import mac_rx_pkg::*;
  import eth_frame_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_TAIL
  } state_t;

  state_t      state;
  frame_load_t pend;      // one frame waiting
  frame_load_t nxt;
  logic        start;
  logic        cur_slot;
  frame_len_t  cur_len;
  logic        cur_tte;
  frame_len_t  rd_idx;
  logic        rd_last;
  logic        out_vld;
  logic        out_last;
  logic        out_tte;
  logic        crc_init;
  crc_t        crc;
  logic        desc_vld;
  logic        desc_tte;
  logic        desc_runt;
  logic        desc_giant;
  frame_len_t  desc_len;

  assign nxt   = pend.valid ? pend : load;
  // the tail cycle keeps the descriptor apart from the next first byte
  assign start = ((state == ST_IDLE) || (state == ST_TAIL)) && nxt.valid;

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      pend <= '0;
    end else if (start && pend.valid) begin
      pend <= load;  // refill or empty
    end else if (!start && load.valid) begin
      pend <= load;
    end
  end

  // ====================
  // read address walk
  // ====================
  assign rd_last = (rd_idx == cur_len - 1'b1);
  assign rd_addr = {cur_slot, rd_idx[SLOT_IDX_W-1:0]};

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      state  <= ST_IDLE;
      rd_idx <= '0;
    end else begin
      case (state)
        ST_READ: begin
          rd_idx <= rd_idx + 1'b1;
          if (rd_last) begin
            state <= ST_TAIL;
          end
        end
        ST_IDLE, ST_TAIL: begin
          rd_idx <= '0;
          state  <= start ? ST_READ : ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge rx_clk) begin
    if (start) begin
      cur_slot <= nxt.slot;
      cur_len  <= nxt.length;
      cur_tte  <= nxt.tte;
    end
  end

  // ====================
  // output byte, aligned to ram latency
  // ====================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      out_vld  <= 1'b0;
      out_last <= 1'b0;
      out_tte  <= 1'b0;
    end else begin
      out_vld  <= (state == ST_READ);
      out_last <= (state == ST_READ) && rd_last;
      out_tte  <= cur_tte;
    end
  end

  assign rx_byte  = '{valid: out_vld, last: out_last, tte: out_tte, data: rd_data};
  assign crc_init = (state == ST_READ) && (rd_idx == '0);

  crc32_8023 u_crc (
    .rx_clk   (rx_clk),
    .rstn_mac (rstn_mac),
    .init     (crc_init),
    .calc     (out_vld),
    .data     (rd_data),
    .crc      (crc)
  );

  // ====================
  // descriptor
  // ====================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      desc_vld <= 1'b0;
    end else begin
      desc_vld <= out_vld && out_last;
    end
  end

  // cur_* still hold this frame in the tail cycle
  always_ff @(posedge rx_clk) begin
    if (out_vld && out_last) begin
      desc_tte   <= out_tte;
      desc_len   <= cur_len;
      desc_runt  <= (cur_len < MIN_FRAME_LEN);
      desc_giant <= (cur_len > MAX_LEGAL_LEN);
    end
  end

  // crc register has taken the last byte by now
  assign rx_desc = '{valid: desc_vld, tte: desc_tte, runt: desc_runt, giant: desc_giant,
                     crc_err: desc_vld && (crc != CRC_RESIDUE), length: desc_len};

endmodule

// ==== source/gmii_rx_framer.sv ====
`timescale 1ns/1ns

module gmii_rx_framer #(
  parameter int MAX_FRAME_LEN = 1519
) (
  input  logic                    rx_clk,
  input  logic                    rstn_mac,
  input  logic                    rx_dv,
  input  mac_rx_pkg::byte_t       gmii_rxd,
  output logic                    wr_en,
  output mac_rx_pkg::ram_addr_t   wr_addr,
  output mac_rx_pkg::byte_t       wr_data,
  output mac_rx_pkg::frame_load_t load
);
  import mac_rx_pkg::*;
  import eth_frame_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PREAMBLE,
    ST_CAPTURE,
    ST_DRAIN
  } state_t;

  state_t      state;
  logic        dv_q;
  byte_t       rxd_q;
  frame_len_t  byte_cnt;  // bytes written into the current slot
  logic        slot;
  logic        tte;
  logic        is_sfd;
  logic        is_pre;
  logic        type_hit;
  logic        at_limit;
  frame_load_t load_q;

  // ====================
  // gmii input register
  // ====================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      dv_q <= 1'b0;
    end else begin
      dv_q <= rx_dv;
    end
  end

  always_ff @(posedge rx_clk) begin
    rxd_q <= gmii_rxd;
  end

  assign is_sfd   = dv_q && (rxd_q == SFD_BYTE);
  assign is_pre   = dv_q && (rxd_q == PREAMBLE_BYTE);
  assign type_hit = (byte_cnt == frame_len_t'(TYPE_BYTE_INDEX)) && (rxd_q == TTE_TYPE_BYTE);
  assign at_limit = (byte_cnt == frame_len_t'(MAX_FRAME_LEN - 1));

  // ====================
  // buffer write port
  // ====================
  assign wr_en   = (state == ST_CAPTURE) && dv_q;
  assign wr_addr = {slot, byte_cnt[SLOT_IDX_W-1:0]};
  assign wr_data = rxd_q;

  // ====================
  // delimiter search and capture
  // ====================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      state    <= ST_IDLE;
      byte_cnt <= '0;
      slot     <= 1'b0;
      tte      <= 1'b0;
      load_q   <= '0;
    end else begin
      load_q.valid <= 1'b0;  // strobe by default
      case (state)
        ST_IDLE: begin
          byte_cnt <= '0;
          tte      <= 1'b0;
          if (is_sfd) begin
            state <= ST_CAPTURE;  // sfd without preamble
          end else if (is_pre) begin
            state <= ST_PREAMBLE;
          end else if (dv_q) begin
            state <= ST_DRAIN;  // junk at start of burst
          end
        end
        ST_PREAMBLE: begin
          if (!dv_q) begin
            state <= ST_IDLE;
          end else if (is_sfd) begin
            state <= ST_CAPTURE;
          end else if (!is_pre) begin
            state <= ST_DRAIN;
          end
        end
        ST_CAPTURE: begin
          if (dv_q) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (type_hit) begin
              tte <= 1'b1;
            end
            // truncate, rest of the burst is dropped
            if (at_limit) begin
              load_q <= '{valid: 1'b1, slot: slot, length: byte_cnt + 1'b1,
                          tte: tte | type_hit};
              slot   <= ~slot;
              state  <= ST_DRAIN;
            end
          end else begin
            // empty frames are not handed over
            if (byte_cnt != '0) begin
              load_q <= '{valid: 1'b1, slot: slot, length: byte_cnt, tte: tte};
              slot   <= ~slot;
            end
            state <= ST_IDLE;
          end
        end
        ST_DRAIN: begin
          if (!dv_q) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign load = load_q;

endmodule

// ==== source/mac_rx_gmii.sv ====
`timescale 1ns/1ns

module mac_rx_gmii #(
  parameter int MAX_FRAME_LEN = 1519  // at most 2047, one slot
) (
  input  logic                 rx_clk,
  input  logic                 rstn_mac,
  input  logic                 rx_dv,
  input  mac_rx_pkg::byte_t    gmii_rxd,
  output mac_rx_pkg::rx_byte_t rx_byte,
  output mac_rx_pkg::rx_desc_t rx_desc
);
  import mac_rx_pkg::*;

  logic        wr_en;
  ram_addr_t   wr_addr;
  byte_t       wr_data;
  ram_addr_t   rd_addr;
  byte_t       rd_data;
  frame_load_t load;

  gmii_rx_framer #(
    .MAX_FRAME_LEN (MAX_FRAME_LEN)
  ) u_framer (
    .rx_clk   (rx_clk),
    .rstn_mac (rstn_mac),
    .rx_dv    (rx_dv),
    .gmii_rxd (gmii_rxd),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .load     (load)
  );

  frame_ram u_ram (
    .rx_clk  (rx_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  frame_unloader u_unloader (
    .rx_clk   (rx_clk),
    .rstn_mac (rstn_mac),
    .load     (load),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rx_byte  (rx_byte),
    .rx_desc  (rx_desc)
  );

endmodule

// ==== source/mac_rx_pkg.sv ====
package mac_rx_pkg;

  // ====================
  // widths
  // ====================
  localparam int BYTE_W     = 8;
  localparam int LEN_W      = 13;
  localparam int SLOT_IDX_W = 11;              // byte index inside one slot
  localparam int RAM_ADDR_W = SLOT_IDX_W + 1;  // slot bit on top
  localparam int CRC_W      = 32;

  typedef logic [BYTE_W-1:0]     byte_t;
  typedef logic [LEN_W-1:0]      frame_len_t;
  typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
  typedef logic [CRC_W-1:0]      crc_t;

  // ====================
  // hand-over records
  // ====================

  // framer -> unloader, one per stored frame
  typedef struct packed {
    logic       valid;   // one-cycle pulse
    logic       slot;
    frame_len_t length;  // bytes after the sfd
    logic       tte;
  } frame_load_t;

  // one output byte
  typedef struct packed {
    logic  valid;
    logic  last;
    logic  tte;
    byte_t data;
  } rx_byte_t;

  // end-of-frame descriptor
  typedef struct packed {
    logic       valid;
    logic       tte;
    logic       runt;
    logic       giant;
    logic       crc_err;
    frame_len_t length;
  } rx_desc_t;

endpackage

// ==== tests/mac_rx_gmii_properties.sv ====
`timescale 1ns/1ns

module mac_rx_gmii_properties (
  input logic                 rx_clk,
  input logic                 rstn_mac,
  input mac_rx_pkg::rx_byte_t rx_byte,
  input mac_rx_pkg::rx_desc_t rx_desc
);

  // ====================
  // descriptor timing
  // ====================
  desc_after_last: assert property (@(posedge rx_clk) disable iff (!rstn_mac)
    (rx_byte.valid && rx_byte.last) |=> rx_desc.valid)
    else $error("no descriptor in the cycle after a last byte");

  desc_only_after_last: assert property (@(posedge rx_clk) disable iff (!rstn_mac)
    rx_desc.valid |-> $past(rx_byte.valid && rx_byte.last))
    else $error("descriptor without a last byte one cycle before");

  byte_desc_apart: assert property (@(posedge rx_clk) disable iff (!rstn_mac)
    !(rx_byte.valid && rx_desc.valid))
    else $error("byte and descriptor valid in the same cycle");

  // ====================
  // reset
  // ====================
  quiet_in_reset: assert property (@(posedge rx_clk)
    !rstn_mac |-> (!rx_byte.valid && !rx_desc.valid))
    else $error("output valid while in reset");

endmodule

bind frame_unloader mac_rx_gmii_properties u_props (
  .rx_clk   (rx_clk),
  .rstn_mac (rstn_mac),
  .rx_byte  (rx_byte),
  .rx_desc  (rx_desc)
);

// ==== tests/mac_rx_gmii_tb.sv ====
`timescale 1ns/1ns

module mac_rx_gmii_tb;
  import mac_rx_pkg::*;
  import eth_frame_pkg::*;

  localparam int   MAX_FRAME_LEN = 1519;
  localparam int   NUM_FRAMES    = 24;
  localparam int   WAIT_LIMIT    = 5000;           // cycles per wait
  localparam crc_t GOOD_RESIDUE  = 32'hDEBB_20E3;  // 802.3 residue in reflected bit order

  logic     rx_clk;
  logic     rstn_mac;
  logic     rx_dv;
  byte_t    gmii_rxd;
  rx_byte_t rx_byte;
  rx_desc_t rx_desc;

  logic [31:0] lfsr = 32'h265f_b2e1;
  rx_byte_t    exp_bytes[$];  // bytes still to come out
  rx_desc_t    exp_desc[$];   // one per frame in flight

  mac_rx_gmii #(
    .MAX_FRAME_LEN (MAX_FRAME_LEN)
  ) u_dut (
    .rx_clk   (rx_clk),
    .rstn_mac (rstn_mac),
    .rx_dv    (rx_dv),
    .gmii_rxd (gmii_rxd),
    .rx_byte  (rx_byte),
    .rx_desc  (rx_desc)
  );

  initial rx_clk = 1'b0;
  always #10 rx_clk = ~rx_clk;

  // ====================
  // helpers
  // ====================

  // fibonacci lfsr with taps 32 22 2 1, stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // reflected crc-32 register without the final inversion
  function automatic crc_t crc_reflected(input byte_t data[$]);
    crc_t c;
    c = '1;
    foreach (data[i]) begin
      c = c ^ {24'h0, data[i]};
      for (int b = 0; b < 8; b++) begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
    end
    return c;
  endfunction

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input logic ok, input string what);
    assert (ok) else begin
      $display("Error at %0t ns: %s", $time, what);
      stop_with_failure();
    end
  endtask

  // polled on the rising edge while the monitor pops on the falling edge
  task automatic wait_outstanding(input int max_left);
    int cnt;
    cnt = 0;
    while (exp_desc.size() > max_left) begin
      @(posedge rx_clk);
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        $display("receive path stalled with %0d frames still expected", exp_desc.size());
        stop_with_failure();
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge rx_clk);
      rx_dv    = 1'b0;
      gmii_rxd = 8'h00;
    end
  endtask

  task automatic drive_byte(input byte_t b);
    @(negedge rx_clk);
    rx_dv    = 1'b1;
    gmii_rxd = b;
  endtask

  // ====================
  // stimulus and model
  // ====================

  // preamble then junk bytes below 80 hex with no delimiter
  task automatic send_junk_burst();
    idle_cycles(12);
    repeat (1 + rand_bits(3)) drive_byte(PREAMBLE_BYTE);
    drive_byte(8'h0F);
    repeat (4 + rand_bits(3)) drive_byte(byte_t'(rand_bits(7)));
  endtask

  task automatic send_frame(input int payload_len, input bit make_tte, input bit bad_fcs);
    byte_t    frm[$];
    byte_t    kept[$];
    crc_t     fcs;
    int       len;
    logic     tte;
    rx_desc_t d;
    for (int i = 0; i < payload_len; i++) begin
      frm.push_back(byte_t'(rand_bits(8)));
    end
    if (make_tte) begin
      frm[TYPE_BYTE_INDEX] = TTE_TYPE_BYTE;
    end
    fcs = ~crc_reflected(frm);
    for (int i = 0; i < 4; i++) begin
      frm.push_back(fcs[8*i +: 8]);  // lsb byte first
    end
    if (bad_fcs) begin
      frm[frm.size()-2] = frm[frm.size()-2] ^ 8'h10;
    end
    // what the receiver keeps
    len = (frm.size() > MAX_FRAME_LEN) ? MAX_FRAME_LEN : frm.size();
    for (int i = 0; i < len; i++) begin
      kept.push_back(frm[i]);
    end
    tte = (len > TYPE_BYTE_INDEX) ? (kept[TYPE_BYTE_INDEX] == TTE_TYPE_BYTE) : 1'b0;
    @(posedge rx_clk);
    wait_outstanding(1);  // two frames at most in the buffer
    for (int i = 0; i < len; i++) begin
      exp_bytes.push_back('{valid: 1'b1, last: (i == len - 1), tte: tte, data: kept[i]});
    end
    d = '{valid: 1'b1, tte: tte, runt: (len < MIN_FRAME_LEN), giant: (len > MAX_LEGAL_LEN),
          crc_err: (crc_reflected(kept) != GOOD_RESIDUE), length: frame_len_t'(len)};
    exp_desc.push_back(d);
    idle_cycles(12 + rand_bits(4) % 9);
    repeat (rand_bits(3)) drive_byte(PREAMBLE_BYTE);
    drive_byte(SFD_BYTE);
    foreach (frm[i]) drive_byte(frm[i]);
    idle_cycles(1);
  endtask

  // ====================
  // output monitor
  // ====================
  task automatic check_outputs();
    rx_byte_t exp_b;
    rx_desc_t exp_d;
    if (rx_byte.valid) begin
      check_value(exp_bytes.size() != 0, "byte out with no frame pending");
      exp_b = exp_bytes.pop_front();
      check_value(rx_byte == exp_b, $sformatf("rx_byte %h, expected %h", rx_byte, exp_b));
    end
    if (rx_desc.valid) begin
      check_value(exp_desc.size() != 0, "descriptor with no frame pending");
      exp_d = exp_desc.pop_front();
      check_value(rx_desc == exp_d, $sformatf("rx_desc %h, expected %h", rx_desc, exp_d));
    end
  endtask

  always @(negedge rx_clk) begin
    if (!rstn_mac) begin
      check_value(!rx_byte.valid && !rx_desc.valid, "output valid during reset");
    end else begin
      check_outputs();
    end
  end

  initial begin
    rstn_mac = 1'b0;
    rx_dv    = 1'b0;
    gmii_rxd = 8'h00;
    repeat (16) @(negedge rx_clk);
    rstn_mac = 1'b1;
    for (int n = 0; n < NUM_FRAMES; n++) begin
      case (n)
        3:  send_frame(60, 1'b1, 1'b0);    // time-triggered
        6:  send_frame(80, 1'b0, 1'b1);    // broken fcs
        9:  send_frame(1530, 1'b0, 1'b0);  // cut at MAX_FRAME_LEN
        12: begin
          send_junk_burst();
          send_frame(70, 1'b0, 1'b0);
        end
        default: send_frame(10 + rand_bits(7), rand_bits(2) == 0, 1'b0);
      endcase
    end
    @(posedge rx_clk);
    wait_outstanding(0);
    repeat (50) @(posedge rx_clk);  // nothing stray afterwards
    assert ((exp_bytes.size() == 0) && (exp_desc.size() == 0)) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("%0d expected bytes never came out", exp_bytes.size());
      stop_with_failure();
    end
  end

endmodule
